// File: include/trace_settings.svh
// trace capture settings
// sizes for the shift buffer, rule set, event FIFO and trigger counters

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

`define TRACE_BUFFER_BITS 64  // 16 nibbles of trace history
`define TRACE_MATCH_RULES 8   // pattern/mask rule slots

`define TRACE_FIFO_DEPTH 16   // power of two, pointers wrap naturally

`define TRACE_TS_BITS 16      // free-running cycle stamp

`define TRACE_DELAY_BITS 20   // trigger delay in trace_clk cycles
`define TRACE_WIDTH_BITS 17   // trigger high time in trace_clk cycles

`define TRACE_COUNT_BITS 8    // saturating match counters

`endif

// File: logic/trace_types_pkg.sv
// trace capture data types
// trace samples, rule configuration, event records and trigger setup

`default_nettype none

`include "trace_settings.svh"

package trace_types_pkg;

   typedef logic [3:0] trace_nibble_t;                        // one TRACEDATA sample
   typedef logic [`TRACE_BUFFER_BITS-1:0] trace_buffer_t;     // newest nibble in [3:0]
   typedef logic [`TRACE_MATCH_RULES-1:0] rule_mask_t;        // one bit per rule
   typedef logic [$clog2(`TRACE_MATCH_RULES)-1:0] rule_idx_t;
   typedef logic [`TRACE_TS_BITS-1:0] trace_ts_t;
   typedef logic [`TRACE_COUNT_BITS-1:0] match_count_t;

   typedef struct packed {
      trace_buffer_t pattern;  // compared bit by bit
      trace_buffer_t mask;     // 1 = bit takes part in the compare
   } rule_cfg_t;

   typedef rule_cfg_t [`TRACE_MATCH_RULES-1:0] rule_cfg_array_t;

   typedef struct packed {
      rule_idx_t rule;         // lands in record bits 18:16
      trace_ts_t timestamp;
   } trace_event_t;

   typedef struct packed {
      logic [`TRACE_DELAY_BITS-1:0] delay;
      logic [`TRACE_WIDTH_BITS-1:0] width;  // 0 disables the pulse
   } trig_cfg_t;

   typedef match_count_t [`TRACE_MATCH_RULES-1:0] match_count_array_t;

endpackage

`default_nettype wire

// File: logic/trace_regs_pkg.sv
// register bus definitions
// strobe bus struct and the byte address map of the capture block

`default_nettype none

package trace_regs_pkg;

   typedef logic [7:0] reg_addr_t;

   typedef struct packed {
      logic      wr;     // one-cycle write strobe
      logic      rd;     // one-cycle read strobe
      reg_addr_t addr;
      logic [7:0] wdata;
   } reg_bus_t;

   localparam reg_addr_t REG_RULE_EN      = 8'h01;  // rule enable bits
   localparam reg_addr_t REG_TRIG_EN      = 8'h02;  // rules allowed to fire the trigger
   localparam reg_addr_t REG_CTRL         = 8'h03;  // bit 0 arm, write clears overflow
   localparam reg_addr_t REG_STATUS       = 8'h04;  // empty, overflow, trigger busy
   localparam reg_addr_t REG_FIFO_B0      = 8'h05;  // event record, little endian
   localparam reg_addr_t REG_FIFO_B1      = 8'h06;
   localparam reg_addr_t REG_FIFO_B2      = 8'h07;  // read pops the FIFO
   localparam reg_addr_t REG_DELAY_B0     = 8'h08;
   localparam reg_addr_t REG_DELAY_B1     = 8'h09;
   localparam reg_addr_t REG_DELAY_B2     = 8'h0A;
   localparam reg_addr_t REG_WIDTH_B0     = 8'h0B;
   localparam reg_addr_t REG_WIDTH_B1     = 8'h0C;
   localparam reg_addr_t REG_WIDTH_B2     = 8'h0D;
   localparam reg_addr_t REG_PATTERN_BASE = 8'h40;  // rule*8 + byte
   localparam reg_addr_t REG_MASK_BASE    = 8'h80;  // rule*8 + byte
   localparam reg_addr_t REG_COUNT_BASE   = 8'hC0;  // + rule

endpackage

`default_nettype wire

// File: logic/trace_regs.sv
// trace capture register block
// byte writes into rule, enable and trigger config; registered read mux

`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_regs (
   input  wire                                 trace_clk,
   input  wire                                 arst_n,
   input  wire trace_regs_pkg::reg_bus_t       bus,
   input  wire trace_types_pkg::match_count_array_t counts,
   input  wire trace_types_pkg::trace_event_t  head,
   input  wire                                 empty,
   input  wire                                 overflow,
   input  wire                                 busy,
   output logic [7:0]                          rdata,
   output logic                                rdata_valid,
   output trace_types_pkg::rule_cfg_array_t    rule_cfg,
   output trace_types_pkg::rule_mask_t         rule_en,
   output trace_types_pkg::rule_mask_t         trig_en,
   output logic                                arm,
   output trace_types_pkg::trig_cfg_t          trig_cfg,
   output logic                                fifo_pop,
   output logic                                overflow_clear
);

   import trace_types_pkg::*;
   import trace_regs_pkg::*;

   rule_idx_t  addr_rule;  // rule slot in the pattern/mask windows
   logic [2:0] addr_low;   // byte lane, or rule in the count window
   logic [1:0] addr_win;   // 64-byte window select
   logic [7:0] rd_mux;

   assign addr_rule = bus.addr[5:3];
   assign addr_low  = bus.addr[2:0];
   assign addr_win  = bus.addr[7:6];

   // side effects of the bus strobes, same edge
   assign fifo_pop       = bus.rd && (bus.addr == REG_FIFO_B2) && !empty;
   assign overflow_clear = bus.wr && (bus.addr == REG_CTRL);

   always_ff @(posedge trace_clk or negedge arst_n) begin
      if (!arst_n) begin
         rule_cfg <= '0;
         rule_en  <= '0;
         trig_en  <= '0;
         arm      <= 1'b0;
         trig_cfg <= '0;
      end else if (bus.wr) begin
         case (bus.addr)
            REG_RULE_EN:  rule_en <= bus.wdata;
            REG_TRIG_EN:  trig_en <= bus.wdata;
            REG_CTRL:     arm     <= bus.wdata[0];  // other bits only clear overflow
            REG_DELAY_B0: trig_cfg.delay[7:0]  <= bus.wdata;
            REG_DELAY_B1: trig_cfg.delay[15:8] <= bus.wdata;
            REG_DELAY_B2: begin
               trig_cfg.delay[`TRACE_DELAY_BITS-1:16] <= bus.wdata[`TRACE_DELAY_BITS-17:0];
            end
            REG_WIDTH_B0: trig_cfg.width[7:0]  <= bus.wdata;
            REG_WIDTH_B1: trig_cfg.width[15:8] <= bus.wdata;
            REG_WIDTH_B2: begin
               trig_cfg.width[`TRACE_WIDTH_BITS-1:16] <= bus.wdata[`TRACE_WIDTH_BITS-17:0];
            end
            default: begin
               if (addr_win == REG_PATTERN_BASE[7:6]) begin
                  rule_cfg[addr_rule].pattern[{addr_low, 3'b000} +: 8] <= bus.wdata;
               end else if (addr_win == REG_MASK_BASE[7:6]) begin
                  rule_cfg[addr_rule].mask[{addr_low, 3'b000} +: 8] <= bus.wdata;
               end
            end
         endcase
      end
   end

   // read source select, unmapped reads give 0
   always_comb begin
      rd_mux = '0;
      case (bus.addr)
         REG_RULE_EN:  rd_mux = rule_en;
         REG_TRIG_EN:  rd_mux = trig_en;
         REG_CTRL:     rd_mux = {7'b0, arm};
         REG_STATUS:   rd_mux = {5'b0, busy, overflow, empty};
         REG_FIFO_B0:  rd_mux = head.timestamp[7:0];
         REG_FIFO_B1:  rd_mux = head.timestamp[15:8];
         REG_FIFO_B2:  rd_mux = 8'(head.rule);  // record bits 23:16
         REG_DELAY_B0: rd_mux = trig_cfg.delay[7:0];
         REG_DELAY_B1: rd_mux = trig_cfg.delay[15:8];
         REG_DELAY_B2: rd_mux = 8'(trig_cfg.delay[`TRACE_DELAY_BITS-1:16]);
         REG_WIDTH_B0: rd_mux = trig_cfg.width[7:0];
         REG_WIDTH_B1: rd_mux = trig_cfg.width[15:8];
         REG_WIDTH_B2: rd_mux = 8'(trig_cfg.width[`TRACE_WIDTH_BITS-1:16]);
         default: begin
            if (addr_win == REG_PATTERN_BASE[7:6]) begin
               rd_mux = rule_cfg[addr_rule].pattern[{addr_low, 3'b000} +: 8];
            end else if (addr_win == REG_MASK_BASE[7:6]) begin
               rd_mux = rule_cfg[addr_rule].mask[{addr_low, 3'b000} +: 8];
            end else if (addr_win == REG_COUNT_BASE[7:6] && bus.addr[5:3] == 3'b000) begin
               rd_mux = counts[addr_low];  // 0xC0..0xC7 only
            end
         end
      endcase
   end

   always_ff @(posedge trace_clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= bus.rd;  // high for the cycle after the strobe
      end
   end

   always_ff @(posedge trace_clk) begin
      if (bus.rd) begin
         rdata <= rd_mux;  // head sampled before the pop lands
      end
   end

endmodule

`default_nettype wire

// File: logic/trace_matcher.sv
// trace pattern matcher
// nibble shift buffer against eight pattern/mask rules, match counters
// and event strobes with a free-running timestamp

`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_matcher (
   input  wire                                    trace_clk,
   input  wire                                    arst_n,
   input  wire trace_types_pkg::trace_nibble_t    trace_data,
   input  wire trace_types_pkg::rule_cfg_array_t  rule_cfg,
   input  wire trace_types_pkg::rule_mask_t       rule_en,
   input  wire trace_types_pkg::rule_mask_t       trig_en,
   input  wire                                    arm,
   output trace_types_pkg::trace_event_t          evt,
   output logic                                   event_valid,
   output logic                                   trig_match,
   output trace_types_pkg::match_count_array_t    counts
);

   import trace_types_pkg::*;

   localparam int RULES = `TRACE_MATCH_RULES;

   trace_buffer_t shift_buf;   // newest nibble in [3:0]
   rule_mask_t    match_d;     // compare against current buffer
   rule_mask_t    match_q;     // one cycle behind the buffer
   rule_idx_t     first_rule;  // lowest matching index
   trace_ts_t     ts_q;

   always_comb begin
      for (int r = 0; r < RULES; r++) begin
         match_d[r] = rule_en[r] &&
                      (((shift_buf ^ rule_cfg[r].pattern) & rule_cfg[r].mask) == '0);
      end
   end

   // priority encoder, rule 0 wins
   always_comb begin
      first_rule = '0;
      for (int i = RULES - 1; i >= 0; i--) begin
         if (match_q[i]) first_rule = rule_idx_t'(i);
      end
   end

   always_ff @(posedge trace_clk or negedge arst_n) begin
      if (!arst_n) begin
         shift_buf <= '0;
         match_q   <= '0;
         counts    <= '0;
         ts_q      <= '0;
      end else begin
         shift_buf <= {shift_buf[`TRACE_BUFFER_BITS-5:0], trace_data};  // older nibbles move up
         match_q   <= match_d;
         ts_q      <= ts_q + 1'b1;  // wraps
         for (int r = 0; r < RULES; r++) begin
            if (match_q[r] && counts[r] != '1) begin
               counts[r] <= counts[r] + 1'b1;  // saturate at all ones
            end
         end
      end
   end

   assign evt.rule      = first_rule;
   assign evt.timestamp = ts_q;
   assign event_valid   = arm && (|match_q);     // nothing stored while disarmed
   assign trig_match    = |(match_q & trig_en);  // arm not needed for the trigger

endmodule

`default_nettype wire

// File: logic/trace_pulse_trigger.sv
// delayed trigger pulse generator
// one pulse of programmable delay and width per accepted match

`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_pulse_trigger (
   input  wire                              trace_clk,
   input  wire                              arst_n,
   input  wire                              trig_match,
   input  wire trace_types_pkg::trig_cfg_t  trig_cfg,
   output logic                             trace_trig_out,
   output logic                             busy
);

   localparam int CNT_BITS = `TRACE_DELAY_BITS;  // wide enough for the width field too

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_DELAY,
      PH_HIGH
   } phase_t;

   phase_t              phase;
   logic [CNT_BITS-1:0] cnt;        // cycles left in the current phase, minus one
   logic [CNT_BITS-1:0] width_ext;
   logic [CNT_BITS-1:0] width_q;    // width taken at start of the pulse

   assign width_ext = CNT_BITS'(trig_cfg.width);

   always_ff @(posedge trace_clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= PH_IDLE;
         cnt   <= '0;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (trig_match && width_ext != '0) begin  // zero width, no pulse
                  if (trig_cfg.delay == '0) begin
                     phase <= PH_HIGH;                   // high right after the match edge
                     cnt   <= width_ext - 1'b1;
                  end else begin
                     phase <= PH_DELAY;
                     cnt   <= trig_cfg.delay - 1'b1;
                  end
               end
            end
            PH_DELAY: begin
               if (cnt == '0) begin
                  phase <= PH_HIGH;
                  cnt   <= width_q - 1'b1;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            PH_HIGH: begin
               if (cnt == '0) phase <= PH_IDLE;
               else cnt <= cnt - 1'b1;
            end
            default: phase <= PH_IDLE;
         endcase
      end
   end

   always_ff @(posedge trace_clk) begin
      if (phase == PH_IDLE) width_q <= width_ext;  // frozen while busy
   end

   assign trace_trig_out = (phase == PH_HIGH);
   assign busy           = (phase != PH_IDLE);  // new matches ignored

endmodule

`default_nettype wire

// File: logic/trace_event_fifo.sv
// match event FIFO
// single-clock circular buffer, drops pushes when full and flags overflow

`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_event_fifo (
   input  wire                                 trace_clk,
   input  wire                                 arst_n,
   input  wire                                 push,
   input  wire trace_types_pkg::trace_event_t  evt,
   input  wire                                 pop,
   input  wire                                 overflow_clear,
   output trace_types_pkg::trace_event_t       head,
   output logic                                empty,
   output logic                                overflow
);

   import trace_types_pkg::*;

   localparam int DEPTH    = `TRACE_FIFO_DEPTH;
   localparam int PTR_BITS = $clog2(DEPTH);

   trace_event_t        mem [DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [PTR_BITS:0]   count;   // 0..DEPTH
   logic                full;
   logic                do_push;
   logic                do_pop;

   assign full    = (count == (PTR_BITS + 1)'(DEPTH));
   assign empty   = (count == '0);
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge trace_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + (PTR_BITS + 1)'(do_push) - (PTR_BITS + 1)'(do_pop);
         if (push && full) overflow <= 1'b1;    // sticky, a lost event outranks the clear
         else if (overflow_clear) overflow <= 1'b0;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (do_push) mem[wr_ptr] <= evt;
   end

   assign head = mem[rd_ptr];  // oldest entry, stale when empty

endmodule

`default_nettype wire

// File: logic/trace_capture_top.sv
// trace capture front end
// register block beside the matcher, pulse trigger and event FIFO

`timescale 1ns/100ps
`default_nettype none

module trace_capture_top (
   input  wire                                trace_clk,
   input  wire                                arst_n,
   input  wire trace_types_pkg::trace_nibble_t trace_data,
   input  wire trace_regs_pkg::reg_bus_t      bus,
   output wire [7:0]                          rdata,
   output wire                                rdata_valid,
   output wire                                trace_trig_out
);

   import trace_types_pkg::*;

   rule_cfg_array_t    rule_cfg;
   rule_mask_t         rule_en;
   rule_mask_t         trig_en;
   logic               arm;
   trig_cfg_t          trig_cfg;
   logic               fifo_pop;
   logic               overflow_clear;
   trace_event_t       evt;          // matcher to FIFO
   logic               event_valid;
   logic               trig_match;
   match_count_array_t counts;
   trace_event_t       head;
   logic               empty;
   logic               overflow;
   logic               busy;

   trace_regs u_regs (
      .trace_clk      (trace_clk),
      .arst_n         (arst_n),
      .bus            (bus),
      .counts         (counts),
      .head           (head),
      .empty          (empty),
      .overflow       (overflow),
      .busy           (busy),
      .rdata          (rdata),
      .rdata_valid    (rdata_valid),
      .rule_cfg       (rule_cfg),
      .rule_en        (rule_en),
      .trig_en        (trig_en),
      .arm            (arm),
      .trig_cfg       (trig_cfg),
      .fifo_pop       (fifo_pop),
      .overflow_clear (overflow_clear)
   );

   trace_matcher u_matcher (
      .trace_clk   (trace_clk),
      .arst_n      (arst_n),
      .trace_data  (trace_data),
      .rule_cfg    (rule_cfg),
      .rule_en     (rule_en),
      .trig_en     (trig_en),
      .arm         (arm),
      .evt         (evt),
      .event_valid (event_valid),
      .trig_match  (trig_match),
      .counts      (counts)
   );

   trace_pulse_trigger u_trigger (
      .trace_clk      (trace_clk),
      .arst_n         (arst_n),
      .trig_match     (trig_match),
      .trig_cfg       (trig_cfg),
      .trace_trig_out (trace_trig_out),
      .busy           (busy)
   );

   trace_event_fifo u_fifo (
      .trace_clk      (trace_clk),
      .arst_n         (arst_n),
      .push           (event_valid),  // every armed match
      .evt            (evt),
      .pop            (fifo_pop),
      .overflow_clear (overflow_clear),
      .head           (head),
      .empty          (empty),
      .overflow       (overflow)
   );

endmodule

`default_nettype wire

// File: sim/trace_capture_properties.sv
// trace capture bus and trigger properties
// bound to the top level, checks read handshake and trigger output rules

`timescale 1ns/100ps
`default_nettype none

module trace_capture_properties (
   input wire                             trace_clk,
   input wire                             arst_n,
   input wire trace_regs_pkg::reg_bus_t   bus,
   input wire                             rdata_valid,
   input wire                             trace_trig_out,
   input wire trace_types_pkg::trig_cfg_t trig_cfg
);

   // read data only in the cycle after a read strobe
   a_rdata_after_read: assert property (
      @(posedge trace_clk) disable iff (!arst_n)
      rdata_valid |-> $past(bus.rd)
   ) else $error("rdata_valid high without a read strobe in the cycle before");

   // output held low in reset and on the first edge out of it
   a_trig_low_in_reset: assert property (
      @(posedge trace_clk) !arst_n |-> !trace_trig_out
   ) else $error("trace_trig_out high during reset");

   a_trig_low_after_reset: assert property (
      @(posedge trace_clk) $rose(arst_n) |-> !trace_trig_out
   ) else $error("trace_trig_out high right after reset");

   // zero width means no pulse at all
   a_trig_needs_width: assert property (
      @(posedge trace_clk) disable iff (!arst_n)
      $rose(trace_trig_out) |-> (trig_cfg.width != '0)
   ) else $error("trace_trig_out rose with a zero width setting");

endmodule

`default_nettype wire

// File: sim/trace_capture_tb.sv
// trace capture testbench
// directed tests for registers, counters, event FIFO, trigger pulse and overflow

`timescale 1ns/100ps
`default_nettype none

`include "trace_settings.svh"

module trace_capture_tb;

   import trace_types_pkg::*;
   import trace_regs_pkg::*;

   localparam int PERIOD      = 40;
   localparam int RUN_CYCLES  = 8 + 40 + 450 + 150 + 150 + 120;  // reset plus each test
   localparam int WATCHDOG_NS = (RUN_CYCLES + RUN_CYCLES / 2) * PERIOD;
   localparam int DLY         = 6;  // trigger delay under test
   localparam int WID         = 4;  // trigger width under test

   logic          trace_clk = 1'b0;
   logic          arst_n;
   trace_nibble_t trace_data;
   reg_bus_t      bus;
   wire [7:0]     rdata;
   wire           rdata_valid;
   wire           trace_trig_out;

   int            cyc = 0;          // edges since start
   int            last_cyc;         // edge that sampled the last sent nibble
   int            errors = 0;
   int            test_errors = 0;
   int            checks = 0;
   int            tests = 0;
   logic [15:0]   lfsr = 16'd15931;
   trace_nibble_t stim[$];          // nibbles queued for the next send

   trace_capture_top dut (
      .trace_clk      (trace_clk),
      .arst_n         (arst_n),
      .trace_data     (trace_data),
      .bus            (bus),
      .rdata          (rdata),
      .rdata_valid    (rdata_valid),
      .trace_trig_out (trace_trig_out)
   );

   bind trace_capture_top trace_capture_properties u_props (
      .trace_clk      (trace_clk),
      .arst_n         (arst_n),
      .bus            (bus),
      .rdata_valid    (rdata_valid),
      .trace_trig_out (trace_trig_out),
      .trig_cfg       (trig_cfg)
   );

   always #(PERIOD / 2) trace_clk = ~trace_clk;

   always @(posedge trace_clk) cyc <= cyc + 1;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
   endfunction

   // 16 nibbles, each 0..7, distinct per rule
   function automatic trace_buffer_t full_pattern(input int rule);
      trace_buffer_t p;
      for (int i = 0; i < 16; i++) p[i*4 +: 4] = 4'((rule * 3 + i) % 8);
      return p;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("Error: t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (test_errors == 0) $display("test %s: ok", name);
      else $display("test %s: %0d mismatches", name, test_errors);
      test_errors = 0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge trace_clk);
         #5;
      end
   endtask

   task automatic bus_write(input reg_addr_t addr, input logic [7:0] data);
      bus.wr    = 1'b1;
      bus.addr  = addr;
      bus.wdata = data;
      idle(1);
      bus.wr = 1'b0;
   endtask

   task automatic bus_read(input reg_addr_t addr, output logic [7:0] data);
      bus.rd   = 1'b1;
      bus.addr = addr;
      idle(1);
      bus.rd = 1'b0;
      check("rdata_valid", rdata_valid, 1);
      data = rdata;  // valid for this cycle only
   endtask

   task automatic read_expect(input reg_addr_t addr, input logic [7:0] exp, input string name);
      logic [7:0] d;
      bus_read(addr, d);
      check(name, d, exp);
   endtask

   task automatic read_record(output logic [2:0] rule, output logic [15:0] ts);
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      bus_read(REG_FIFO_B0, b0);
      bus_read(REG_FIFO_B1, b1);
      bus_read(REG_FIFO_B2, b2);  // pops
      rule = b2[2:0];
      ts   = {b1, b0};
   endtask

   task automatic write_rule(input int rule, input trace_buffer_t pat, input trace_buffer_t msk);
      for (int b = 0; b < 8; b++) begin
         bus_write(REG_PATTERN_BASE + reg_addr_t'(rule * 8 + b), pat[b*8 +: 8]);
         bus_write(REG_MASK_BASE + reg_addr_t'(rule * 8 + b), msk[b*8 +: 8]);
      end
   endtask

   // top bit set, so no filler nibble equals a pattern nibble
   task automatic add_filler(input int n);
      trace_nibble_t f;
      repeat (n) begin
         for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            f[b] = lfsr[15];
         end
         f[3] = 1'b1;
         stim.push_back(f);
      end
   endtask

   task automatic add_pattern(input trace_buffer_t p);
      for (int i = 15; i >= 0; i--) stim.push_back(p[i*4 +: 4]);  // oldest first
   endtask

   task automatic send_nibbles();
      while (stim.size() > 0) begin
         trace_data = stim.pop_front();
         idle(1);
      end
      last_cyc   = cyc;
      trace_data = 4'hF;  // idle value matches no rule
   endtask

   task automatic watch_trigger(input int span, output int rises, output int highs,
                                output int first);
      logic prev;
      rises = 0;
      highs = 0;
      first = -1;
      prev  = trace_trig_out;
      repeat (span) begin
         idle(1);
         if (trace_trig_out && !prev) begin
            rises++;
            if (first < 0) first = cyc;
         end
         if (trace_trig_out) highs++;
         prev = trace_trig_out;
      end
   endtask

   task automatic test_registers();
      read_expect(REG_RULE_EN, 8'h00, "rule_en reset");
      read_expect(REG_CTRL, 8'h00, "ctrl reset");
      read_expect(REG_STATUS, 8'h01, "status reset");  // only empty set
      read_expect(REG_PATTERN_BASE + 8'h0B, 8'h00, "pattern reset");
      read_expect(REG_COUNT_BASE + 8'h02, 8'h00, "count reset");
      bus_write(REG_PATTERN_BASE + 8'h0B, 8'hA5);
      bus_write(REG_MASK_BASE + 8'h3A, 8'h3C);
      bus_write(REG_DELAY_B2, 8'h0F);
      bus_write(REG_WIDTH_B1, 8'h96);
      bus_write(REG_TRIG_EN, 8'h5A);
      read_expect(REG_PATTERN_BASE + 8'h0B, 8'hA5, "pattern byte");
      read_expect(REG_MASK_BASE + 8'h3A, 8'h3C, "mask byte");
      read_expect(REG_DELAY_B2, 8'h0F, "delay_b2");
      read_expect(REG_WIDTH_B1, 8'h96, "width_b1");
      read_expect(REG_TRIG_EN, 8'h5A, "trig_en");
      bus_write(REG_TRIG_EN, 8'h00);
      finish_test("register readback");
   endtask

   task automatic test_counting();
      trace_buffer_t partial;
      write_rule(1, full_pattern(1), '1);
      write_rule(2, full_pattern(2), '1);
      write_rule(3, full_pattern(3), 64'hFFFF);       // four newest nibbles only
      write_rule(4, 64'h0, 64'hF);
      bus_write(REG_RULE_EN, 8'h06);
      repeat (3) begin
         add_pattern(full_pattern(2));
         add_filler(4);
      end
      send_nibbles();
      idle(3);
      read_expect(REG_COUNT_BASE + 8'h02, 8'd3, "count rule 2");
      read_expect(REG_COUNT_BASE + 8'h01, 8'd0, "count rule 1");
      bus_write(REG_RULE_EN, 8'h08);
      add_filler(12);
      partial = full_pattern(3);
      for (int i = 3; i >= 0; i--) stim.push_back(partial[i*4 +: 4]);
      send_nibbles();
      idle(3);
      read_expect(REG_COUNT_BASE + 8'h03, 8'd1, "count rule 3");
      bus_write(REG_RULE_EN, 8'h10);
      repeat (260) stim.push_back(4'h0);
      send_nibbles();
      idle(3);
      read_expect(REG_COUNT_BASE + 8'h04, 8'd255, "count rule 4 saturated");
      finish_test("counting");
   endtask

   task automatic test_events();
      logic [2:0]  r1;
      logic [2:0]  r2;
      logic [15:0] t1;
      logic [15:0] t2;
      logic [7:0]  st;
      write_rule(5, full_pattern(5), '1);
      bus_write(REG_RULE_EN, 8'h22);
      bus_write(REG_CTRL, 8'h01);
      add_pattern(full_pattern(1));
      add_filler(4);
      add_pattern(full_pattern(5));                   // completes 20 nibbles later
      send_nibbles();
      idle(3);
      bus_write(REG_CTRL, 8'h00);
      read_record(r1, t1);
      read_record(r2, t2);
      check("first event rule", r1, 1);
      check("second event rule", r2, 5);
      check("timestamp delta", 16'(t2 - t1), 20);
      bus_read(REG_STATUS, st);
      check("status empty after pops", st[0], 1);
      add_pattern(full_pattern(1));
      send_nibbles();
      idle(3);
      bus_read(REG_STATUS, st);
      check("status empty while disarmed", st[0], 1);
      finish_test("event capture");
   endtask

   task automatic test_trigger();
      int rises;
      int highs;
      int first;
      write_rule(7, 64'h5, 64'hF);
      write_rule(0, 64'h6, 64'hF);
      bus_write(REG_DELAY_B0, 8'(DLY));
      bus_write(REG_DELAY_B2, 8'h00);
      bus_write(REG_WIDTH_B0, 8'(WID));
      bus_write(REG_WIDTH_B1, 8'h00);
      bus_write(REG_RULE_EN, 8'h81);
      bus_write(REG_TRIG_EN, 8'h80);
      stim.push_back(4'h5);
      send_nibbles();
      watch_trigger(DLY + WID + 10, rises, highs, first);
      check("single pulse count", rises, 1);
      check("pulse rise edge", first, last_cyc + DLY + 2);
      check("pulse width", highs, WID);
      stim.push_back(4'h5);
      add_filler(2);
      stim.push_back(4'h5);                            // lands while busy
      send_nibbles();
      watch_trigger(DLY + WID + 10, rises, highs, first);
      check("pulses with match during busy", rises, 1);
      check("first pulse rise edge", first, last_cyc - 3 + DLY + 2);
      stim.push_back(4'h6);
      send_nibbles();
      watch_trigger(DLY + WID + 10, rises, highs, first);
      check("pulses from untriggered rule", rises, 0);
      bus_write(REG_WIDTH_B0, 8'h00);                 // whole width field now zero
      stim.push_back(4'h5);
      send_nibbles();
      watch_trigger(DLY + WID + 10, rises, highs, first);
      check("pulses with zero width", rises, 0);
      bus_write(REG_TRIG_EN, 8'h00);
      finish_test("trigger pulse");
   endtask

   task automatic test_overflow();
      logic [2:0]  r;
      logic [15:0] t;
      logic [15:0] t_prev;
      logic [7:0]  st;
      bus_write(REG_RULE_EN, 8'h80);
      bus_write(REG_CTRL, 8'h01);
      repeat (`TRACE_FIFO_DEPTH + 1) stim.push_back(4'h5);  // one match per nibble
      send_nibbles();
      idle(3);
      bus_read(REG_STATUS, st);
      check("overflow set", st[1], 1);
      for (int i = 0; i < `TRACE_FIFO_DEPTH; i++) begin
         read_record(r, t);
         check("overflow record rule", r, 7);
         if (i > 0) check("overflow record step", 16'(t - t_prev), 1);
         t_prev = t;
      end
      bus_read(REG_STATUS, st);
      check("empty after 16 reads", st[0], 1);
      check("overflow still set", st[1], 1);
      bus_write(REG_CTRL, 8'h00);
      bus_read(REG_STATUS, st);
      check("overflow cleared", st[1], 0);
      finish_test("overflow");
   endtask

   initial begin
      arst_n     = 1'b0;
      trace_data = 4'hF;
      bus        = '0;
      repeat (8) @(posedge trace_clk);
      #5;
      arst_n = 1'b1;
      idle(2);
      test_registers();
      test_counting();
      test_events();
      test_trigger();
      test_overflow();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/trace_types_pkg.sv
logic/trace_regs_pkg.sv
logic/trace_regs.sv
logic/trace_matcher.sv
logic/trace_pulse_trigger.sv
logic/trace_event_fifo.sv
logic/trace_capture_top.sv
sim/trace_capture_properties.sv
sim/trace_capture_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = trace_capture_tb
FILELIST  = filelist.f
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
